// ==== common/rw_cfg_pkg.sv ====
// Stream word formats for the read/write request generator
// A setup word opens each job, then count data words follow
`default_nettype none

package rw_cfg_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int word_w  = 64;
    localparam int count_w = 16;
    localparam int seq_w   = 8;
    localparam int shift_w = 5;

    // Job FSM encoding
    localparam int         state_w  = 2;
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_setup  = 2'd1;
    localparam logic [1:0] st_stream = 2'd2;
    localparam logic [1:0] st_drain  = 2'd3;

    // First word of a job
    typedef struct packed {
        logic               mode_write;
        logic [shift_w-1:0] shift;
        logic [9:0]         reserved;
        logic [count_w-1:0] count;
        logic [31:0]        base_address;
    } rw_setup_t;

    // Every following word
    typedef struct packed {
        logic [23:0]      reserved;
        logic [seq_w-1:0] seq_id;
        logic [31:0]      index;
    } rw_data_t;

    // Meaning depends on the word's position in the job
    typedef union packed {
        rw_setup_t setup;
        rw_data_t  data;
    } rw_word_u;

endpackage

`default_nettype wire

// ==== common/rw_mem_pkg.sv ====
// Memory side sizes for the read/write request generator
// Request and response field widths, FIFO depths and counter width
`default_nettype none

package rw_mem_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Packed FIFO records
    localparam int req_rec_w  = 1 + addr_w + data_w + rw_cfg_pkg::seq_w;
    localparam int resp_rec_w = data_w + rw_cfg_pkg::seq_w;

    localparam int req_fifo_depth  = 16;
    localparam int resp_fifo_depth = 16;

    // Room left for words still in the address pipeline
    localparam int nearly_full_margin = 4;

    // One bit wider than the job count
    localparam int outstanding_w = 17;

endpackage

`default_nettype wire

// ==== hw/sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO
// The head entry shows on dout while empty is low, and nearly_full
// warns when only the package margin of entries is left
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 16
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    output logic             full,
    output logic             nearly_full,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             empty
);

    logic [width-1:0]         mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   count;
    logic                     push;
    logic                     pop;

    // Writes when full and reads when empty are dropped
    assign push = wr_en & ~full;
    assign pop  = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    assign dout        = mem[rd_ptr];
    assign empty       = (count == 0);
    assign full        = (count == depth);
    assign nearly_full = (count >= depth - rw_mem_pkg::nearly_full_margin);

endmodule

`default_nettype wire

// ==== hw/rw_generator/rw_setup_decode.sv ====
// Job FSM of the request generator
// Reads the setup word, passes data words on to address execute,
// then waits for all responses before raising done
`timescale 1ns/1ps
`default_nettype none

module rw_setup_decode (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  logic                           start,
    input  logic                           engine_in_valid,
    input  rw_cfg_pkg::rw_word_u           engine_in_word,
    output logic                           engine_in_ready,
    input  logic                           req_nearly_full,
    input  logic                           outstanding_zero,
    output logic                           word_valid,
    output logic [rw_mem_pkg::data_w-1:0]  word_index,
    output logic [rw_cfg_pkg::seq_w-1:0]   word_seq_id,
    output logic [rw_cfg_pkg::shift_w-1:0] cfg_shift,
    output logic [rw_mem_pkg::addr_w-1:0]  cfg_base,
    output logic                           cfg_write,
    output logic                           word_accept,
    output logic                           done
);

    logic [rw_cfg_pkg::state_w-1:0] state;
    logic [rw_cfg_pkg::count_w-1:0] words_left;
    logic                           in_xfer;

    // Setup word is always taken, data words only with FIFO room
    always_comb begin
        case (state)
            rw_cfg_pkg::st_setup:  engine_in_ready = 1'b1;
            rw_cfg_pkg::st_stream: engine_in_ready = ~req_nearly_full;
            default:               engine_in_ready = 1'b0;
        endcase
    end

    assign in_xfer     = engine_in_valid & engine_in_ready;
    assign word_valid  = in_xfer & (state == rw_cfg_pkg::st_stream);
    assign word_accept = word_valid;

    // Data view of the current word
    assign word_index  = engine_in_word.data.index;
    assign word_seq_id = engine_in_word.data.seq_id;

    // ----------------------------------------
    // Job FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state      <= rw_cfg_pkg::st_idle;
            words_left <= '0;
            done       <= 1'b0;
        end else begin
            case (state)
                rw_cfg_pkg::st_idle: begin
                    if (start) begin
                        state <= rw_cfg_pkg::st_setup;
                        done  <= 1'b0;
                    end
                end
                rw_cfg_pkg::st_setup: begin
                    if (in_xfer) begin
                        words_left <= engine_in_word.setup.count;
                        // Empty job skips the stream phase
                        if (engine_in_word.setup.count == '0) begin
                            state <= rw_cfg_pkg::st_drain;
                        end else begin
                            state <= rw_cfg_pkg::st_stream;
                        end
                    end
                end
                rw_cfg_pkg::st_stream: begin
                    if (in_xfer) begin
                        words_left <= words_left - 1'b1;
                        if (words_left == 1) begin
                            state <= rw_cfg_pkg::st_drain;
                        end
                    end
                end
                default: begin
                    // Drain until every response is back
                    if (outstanding_zero) begin
                        done  <= 1'b1;
                        state <= rw_cfg_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    // Job configuration from the setup view
    always_ff @(posedge ap_clk) begin
        if (in_xfer && state == rw_cfg_pkg::st_setup) begin
            cfg_shift <= engine_in_word.setup.shift;
            cfg_base  <= engine_in_word.setup.base_address;
            cfg_write <= engine_in_word.setup.mode_write;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rw_generator/rw_address_execute.sv ====
// Address pipeline of the request generator
// Stage 1 shifts the index, stage 2 adds the base, and the request
// FIFO holds the records until memory takes them
`timescale 1ns/1ps
`default_nettype none

module rw_address_execute (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  logic                           word_valid,
    input  logic [rw_mem_pkg::data_w-1:0]  word_index,
    input  logic [rw_cfg_pkg::seq_w-1:0]   word_seq_id,
    input  logic [rw_cfg_pkg::shift_w-1:0] cfg_shift,
    input  logic [rw_mem_pkg::addr_w-1:0]  cfg_base,
    input  logic                           cfg_write,
    output logic                           req_nearly_full,
    output logic                           mem_req_valid,
    output logic                           mem_req_write,
    output logic [rw_mem_pkg::addr_w-1:0]  mem_req_address,
    output logic [rw_mem_pkg::data_w-1:0]  mem_req_data,
    output logic [rw_cfg_pkg::seq_w-1:0]   mem_req_seq_id,
    input  logic                           mem_req_ready
);

    logic                             s1_valid;
    logic [rw_mem_pkg::addr_w-1:0]    s1_offset;
    logic [rw_mem_pkg::data_w-1:0]    s1_index;
    logic [rw_cfg_pkg::seq_w-1:0]     s1_seq_id;
    logic                             s1_write;
    logic                             s2_valid;
    logic [rw_mem_pkg::req_rec_w-1:0] s2_record;
    logic [rw_mem_pkg::req_rec_w-1:0] req_dout;
    logic                             req_empty;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= word_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        // Stage 1
        s1_offset <= word_index << cfg_shift;
        s1_index  <= word_index;
        s1_seq_id <= word_seq_id;
        s1_write  <= cfg_write;
        // Stage 2 record is write, address, data, tag
        s2_record <= {s1_write, cfg_base + s1_offset, s1_index, s1_seq_id};
    end

    sync_fifo #(
        .width (rw_mem_pkg::req_rec_w),
        .depth (rw_mem_pkg::req_fifo_depth)
    ) u_req_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (s2_valid),
        .din              (s2_record),
        .full             (),
        .nearly_full      (req_nearly_full),
        .rd_en            (mem_req_ready),
        .dout             (req_dout),
        .empty            (req_empty)
    );

    assign mem_req_valid = ~req_empty;
    assign {mem_req_write, mem_req_address, mem_req_data, mem_req_seq_id} = req_dout;

endmodule

`default_nettype wire

// ==== hw/rw_generator/rw_response_result.sv ====
// Response side of the request generator
// Buffers memory responses toward the engine and tracks how many
// accepted words still wait for their response
`timescale 1ns/1ps
`default_nettype none

module rw_response_result (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          word_accept,
    input  logic                          mem_resp_valid,
    input  logic [rw_mem_pkg::data_w-1:0] mem_resp_data,
    input  logic [rw_cfg_pkg::seq_w-1:0]  mem_resp_seq_id,
    output logic                          mem_resp_ready,
    output logic                          engine_out_valid,
    output logic [rw_mem_pkg::data_w-1:0] engine_out_data,
    output logic [rw_cfg_pkg::seq_w-1:0]  engine_out_seq_id,
    input  logic                          engine_out_ready,
    output logic                          outstanding_zero
);

    logic [rw_mem_pkg::resp_rec_w-1:0]    resp_dout;
    logic                                 resp_full;
    logic                                 resp_empty;
    logic                                 out_xfer;
    logic [rw_mem_pkg::outstanding_w-1:0] outstanding;

    sync_fifo #(
        .width (rw_mem_pkg::resp_rec_w),
        .depth (rw_mem_pkg::resp_fifo_depth)
    ) u_resp_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (mem_resp_valid),
        .din              ({mem_resp_data, mem_resp_seq_id}),
        .full             (resp_full),
        .nearly_full      (),
        .rd_en            (engine_out_ready),
        .dout             (resp_dout),
        .empty            (resp_empty)
    );

    assign mem_resp_ready   = ~resp_full;
    assign engine_out_valid = ~resp_empty;
    assign {engine_out_data, engine_out_seq_id} = resp_dout;
    assign out_xfer = engine_out_valid & engine_out_ready;

    // ----------------------------------------
    // Outstanding work counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else begin
            case ({word_accept, out_xfer})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign outstanding_zero = (outstanding == '0);

endmodule

`default_nettype wire

// ==== hw/rw_generator/rw_generator_top.sv ====
// Read/write request generator for one engine lane
// Setup decode feeds address execute toward memory, and the response
// result block returns memory answers to the engine
`timescale 1ns/1ps
`default_nettype none

module rw_generator_top (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          start,
    input  logic                          engine_in_valid,
    input  rw_cfg_pkg::rw_word_u          engine_in_word,
    output logic                          engine_in_ready,
    output logic                          mem_req_valid,
    output logic                          mem_req_write,
    output logic [rw_mem_pkg::addr_w-1:0] mem_req_address,
    output logic [rw_mem_pkg::data_w-1:0] mem_req_data,
    output logic [rw_cfg_pkg::seq_w-1:0]  mem_req_seq_id,
    input  logic                          mem_req_ready,
    input  logic                          mem_resp_valid,
    input  logic [rw_mem_pkg::data_w-1:0] mem_resp_data,
    input  logic [rw_cfg_pkg::seq_w-1:0]  mem_resp_seq_id,
    output logic                          mem_resp_ready,
    output logic                          engine_out_valid,
    output logic [rw_mem_pkg::data_w-1:0] engine_out_data,
    output logic [rw_cfg_pkg::seq_w-1:0]  engine_out_seq_id,
    input  logic                          engine_out_ready,
    output logic                          done
);

    logic                           word_valid;
    logic [rw_mem_pkg::data_w-1:0]  word_index;
    logic [rw_cfg_pkg::seq_w-1:0]   word_seq_id;
    logic [rw_cfg_pkg::shift_w-1:0] cfg_shift;
    logic [rw_mem_pkg::addr_w-1:0]  cfg_base;
    logic                           cfg_write;
    logic                           word_accept;
    logic                           req_nearly_full;
    logic                           outstanding_zero;

    rw_setup_decode u_decode (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .engine_in_valid  (engine_in_valid),
        .engine_in_word   (engine_in_word),
        .engine_in_ready  (engine_in_ready),
        .req_nearly_full  (req_nearly_full),
        .outstanding_zero (outstanding_zero),
        .word_valid       (word_valid),
        .word_index       (word_index),
        .word_seq_id      (word_seq_id),
        .cfg_shift        (cfg_shift),
        .cfg_base         (cfg_base),
        .cfg_write        (cfg_write),
        .word_accept      (word_accept),
        .done             (done)
    );

    rw_address_execute u_execute (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .word_valid       (word_valid),
        .word_index       (word_index),
        .word_seq_id      (word_seq_id),
        .cfg_shift        (cfg_shift),
        .cfg_base         (cfg_base),
        .cfg_write        (cfg_write),
        .req_nearly_full  (req_nearly_full),
        .mem_req_valid    (mem_req_valid),
        .mem_req_write    (mem_req_write),
        .mem_req_address  (mem_req_address),
        .mem_req_data     (mem_req_data),
        .mem_req_seq_id   (mem_req_seq_id),
        .mem_req_ready    (mem_req_ready)
    );

    rw_response_result u_result (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .word_accept       (word_accept),
        .mem_resp_valid    (mem_resp_valid),
        .mem_resp_data     (mem_resp_data),
        .mem_resp_seq_id   (mem_resp_seq_id),
        .mem_resp_ready    (mem_resp_ready),
        .engine_out_valid  (engine_out_valid),
        .engine_out_data   (engine_out_data),
        .engine_out_seq_id (engine_out_seq_id),
        .engine_out_ready  (engine_out_ready),
        .outstanding_zero  (outstanding_zero)
    );

endmodule

`default_nettype wire

// ==== tests/rw_checker.sv ====
// Transfer checker for the request generator testbench
// Holds the expected memory requests and engine responses of the
// running job, compares every transfer and counts passing tests
`timescale 1ns/1ps
`default_nettype none

module rw_checker (
    input logic                          ap_clk,
    input logic                          areset_generator,
    input logic                          mem_req_valid,
    input logic                          mem_req_ready,
    input logic                          mem_req_write,
    input logic [rw_mem_pkg::addr_w-1:0] mem_req_address,
    input logic [rw_mem_pkg::data_w-1:0] mem_req_data,
    input logic [rw_cfg_pkg::seq_w-1:0]  mem_req_seq_id,
    input logic                          engine_out_valid,
    input logic                          engine_out_ready,
    input logic [rw_mem_pkg::data_w-1:0] engine_out_data,
    input logic [rw_cfg_pkg::seq_w-1:0]  engine_out_seq_id,
    input logic                          done
);

    // Request record is write, address, data, tag
    logic [rw_mem_pkg::req_rec_w-1:0]  req_q [$];
    logic [rw_mem_pkg::resp_rec_w-1:0] out_q [$];
    logic [rw_mem_pkg::req_rec_w-1:0]  req_exp;
    logic [rw_mem_pkg::resp_rec_w-1:0] out_exp;
    int                                test_errors = 0;
    int                                tests_passed = 0;
    int                                tests_failed = 0;

    // Reads return the address, writes echo the index
    task automatic expect_word(input logic write, input logic [31:0] address,
                               input logic [31:0] index, input logic [7:0] seq_id);
        req_q.push_back({write, address, index, seq_id});
        out_q.push_back({(write ? index : address), seq_id});
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic record_failure(input string what);
        $display("%s", what);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        if (req_q.size() != 0 || out_q.size() != 0) begin
            $display("%s: %0d requests and %0d responses never arrived",
                     name, req_q.size(), out_q.size());
            test_errors++;
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAILED %s with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ----------------------------------------
    // Transfer monitor
    // ----------------------------------------
    always @(posedge ap_clk) begin
        if (!areset_generator) begin
            if (mem_req_valid && mem_req_ready) begin
                if (req_q.size() == 0) begin
                    record_failure($sformatf("Unexpected memory request at t=%0t", $time));
                end else begin
                    req_exp = req_q.pop_front();
                    compare("mem_req_write", req_exp[72], mem_req_write);
                    compare("mem_req_address", req_exp[71:40], mem_req_address);
                    compare("mem_req_data", req_exp[39:8], mem_req_data);
                    compare("mem_req_seq_id", req_exp[7:0], mem_req_seq_id);
                end
            end
            if (engine_out_valid && engine_out_ready) begin
                if (out_q.size() == 0) begin
                    record_failure($sformatf("Unexpected engine output at t=%0t", $time));
                end else begin
                    out_exp = out_q.pop_front();
                    compare("engine_out_data", out_exp[39:8], engine_out_data);
                    compare("engine_out_seq_id", out_exp[7:0], engine_out_seq_id);
                end
            end
            // Done must wait for the last response
            if (done && out_q.size() != 0) begin
                record_failure($sformatf("Done was high at t=%0t with %0d responses pending",
                                         $time, out_q.size()));
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_rw_generator.sv ====
// Testbench for the read/write request generator
// Replays the jobs of the trace file, models a memory that answers
// in order and stalls both ready inputs from an LFSR
`timescale 1ns/1ps
`default_nettype none

module tb_rw_generator;

    logic                          ap_clk;
    logic                          areset_generator;
    logic                          start;
    logic                          engine_in_valid;
    rw_cfg_pkg::rw_word_u          engine_in_word;
    logic                          engine_in_ready;
    logic                          mem_req_valid;
    logic                          mem_req_write;
    logic [rw_mem_pkg::addr_w-1:0] mem_req_address;
    logic [rw_mem_pkg::data_w-1:0] mem_req_data;
    logic [rw_cfg_pkg::seq_w-1:0]  mem_req_seq_id;
    logic                          mem_req_ready;
    logic                          mem_resp_valid;
    logic [rw_mem_pkg::data_w-1:0] mem_resp_data;
    logic [rw_cfg_pkg::seq_w-1:0]  mem_resp_seq_id;
    logic                          mem_resp_ready;
    logic                          engine_out_valid;
    logic [rw_mem_pkg::data_w-1:0] engine_out_data;
    logic [rw_cfg_pkg::seq_w-1:0]  engine_out_seq_id;
    logic                          engine_out_ready;
    logic                          done;

    // Five hex columns per trace line
    logic [31:0] trace_mem [0:127];
    logic [39:0] resp_q [$];
    logic [31:0] lfsr = 32'h9c2b;
    int          job_num = 0;

    rw_generator_top u_dut (.*);

    rw_checker u_checker (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .mem_req_valid     (mem_req_valid),
        .mem_req_ready     (mem_req_ready),
        .mem_req_write     (mem_req_write),
        .mem_req_address   (mem_req_address),
        .mem_req_data      (mem_req_data),
        .mem_req_seq_id    (mem_req_seq_id),
        .engine_out_valid  (engine_out_valid),
        .engine_out_ready  (engine_out_ready),
        .engine_out_data   (engine_out_data),
        .engine_out_seq_id (engine_out_seq_id),
        .done              (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // ----------------------------------------
    // In-order memory model
    // ----------------------------------------
    always @(posedge ap_clk) begin
        if (!areset_generator) begin
            if (mem_req_valid && mem_req_ready) begin
                resp_q.push_back({(mem_req_write ? mem_req_data : mem_req_address),
                                  mem_req_seq_id});
            end
            if (mem_resp_valid && mem_resp_ready) begin
                void'(resp_q.pop_front());
            end
        end
    end

    always @(negedge ap_clk) begin
        lfsr = lfsr_step(lfsr);
        mem_req_ready = lfsr[0];
        lfsr = lfsr_step(lfsr);
        engine_out_ready = lfsr[0];
        mem_resp_valid = (resp_q.size() != 0);
        if (resp_q.size() != 0) begin
            {mem_resp_data, mem_resp_seq_id} = resp_q[0];
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_word(input rw_cfg_pkg::rw_word_u word);
        int waited;
        waited = 0;
        engine_in_valid = 1'b1;
        engine_in_word = word;
        @(posedge ap_clk);
        while (!engine_in_ready) begin
            waited++;
            if (waited > 1000) abort_on_timeout("an engine input word was never accepted");
            @(posedge ap_clk);
        end
        @(negedge ap_clk);
        engine_in_valid = 1'b0;
    endtask

    task automatic run_job(inout int pos);
        rw_cfg_pkg::rw_word_u word;
        logic                 write;
        int                   count;
        int                   k;
        int                   waited;
        write = trace_mem[pos+1][0];
        count = trace_mem[pos+3][15:0];
        word = '0;
        word.setup.mode_write = write;
        word.setup.shift = trace_mem[pos+2][4:0];
        word.setup.count = trace_mem[pos+3][15:0];
        word.setup.base_address = trace_mem[pos+4];
        pos = pos + 5;
        job_num++;
        start = 1'b1;
        @(negedge ap_clk);
        start = 1'b0;
        u_checker.compare("done", 32'h0, done);
        for (k = 0; k < count; k++) begin
            u_checker.expect_word(write, trace_mem[pos+5*k+3], trace_mem[pos+5*k+1],
                                  trace_mem[pos+5*k+2][7:0]);
        end
        send_word(word);
        for (k = 0; k < count; k++) begin
            word = '0;
            word.data.index = trace_mem[pos+5*k+1];
            word.data.seq_id = trace_mem[pos+5*k+2][7:0];
            send_word(word);
        end
        pos = pos + 5 * count;
        waited = 0;
        @(posedge ap_clk);
        while (!done) begin
            waited++;
            if (waited > 2000) abort_on_timeout("done did not rise at the end of a job");
            @(posedge ap_clk);
        end
        @(negedge ap_clk);
        u_checker.end_test($sformatf("job %0d %s count %0d", job_num,
                                     (write ? "write" : "read"), count));
    endtask

    initial begin : main_flow
        int pos;
        areset_generator = 1'b1;
        start = 1'b0;
        engine_in_valid = 1'b0;
        engine_in_word = '0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        mem_resp_seq_id = '0;
        engine_out_ready = 1'b0;
        $readmemh("tests/rw_trace.txt", trace_mem);
        repeat (5) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        @(negedge ap_clk);
        // Quiet outputs before the first start
        u_checker.compare("engine_in_ready", 32'h0, engine_in_ready);
        u_checker.compare("mem_req_valid", 32'h0, mem_req_valid);
        u_checker.compare("engine_out_valid", 32'h0, engine_out_valid);
        u_checker.compare("done", 32'h0, done);
        // Empty response FIFO takes memory responses
        u_checker.compare("mem_resp_ready", 32'h1, mem_resp_ready);
        u_checker.end_test("reset state");
        pos = 0;
        while (pos < 124 && trace_mem[pos] === 32'h1) begin
            run_job(pos);
        end
        if (job_num == 0) begin
            u_checker.record_failure("No job was found in the trace file");
            u_checker.end_test("trace contents");
        end
        $display("Tests passed: %0d, tests failed: %0d",
                 u_checker.tests_passed, u_checker.tests_failed);
        if (u_checker.tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/rw_cfg_pkg.sv
common/rw_mem_pkg.sv
hw/sync_fifo.sv
hw/rw_generator/rw_setup_decode.sv
hw/rw_generator/rw_address_execute.sv
hw/rw_generator/rw_response_result.sv
hw/rw_generator/rw_generator_top.sv
tests/rw_checker.sv
tests/tb_rw_generator.sv

// ==== tests/rw_trace.txt ====
// Columns: kind a b c d, all hex. Kind 1 is a job setup: mode_write shift count base
// Kind 2 is a data word: index tag expected_address 0. Kind f ends the trace
1 0 02 0003 00001000
2 00000001 01 00001004 0
2 00000005 02 00001014 0
2 0000000a 03 00001028 0
1 1 00 0003 80000000
2 00000010 11 80000010 0
2 00000020 12 80000020 0
2 00000333 13 80000333 0
1 0 03 0000 00004000
1 0 04 0004 0000fff0
2 00000001 21 00010000 0
2 00000002 22 00010010 0
2 000000ff 23 00010fe0 0
2 0fffffff 24 0000ffe0 0
f 0 0 0 0
